// File: src.f
design/jpeg_pkg.sv
design/quant_table_regs.sv
design/coef_quantizer.sv
design/zigzag_buffer.sv
design/jpeg_quant_zigzag.sv
tests/tb_quant_zigzag.sv

// File: run.sh
#!/bin/sh
# Build and run the quantize and zigzag testbench with Verilator.
# Passes only when the simulation log holds the pass line.

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_quant_zigzag \
    && ./obj_dir/Vtb_quant_zigzag > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tests/tb_quant_zigzag.sv
`timescale 1ns/100ps

module tb_quant_zigzag;

    localparam int CW = 12;

    // A block needs 64 write cycles plus its reads, a table load one cycle per entry
    localparam int NUM_BLOCKS      = 9;
    localparam int NUM_TABLE_LOADS = 2;
    localparam int BLOCK_CYCLES    = 100;
    localparam int CYCLE_LIMIT     = BLOCK_CYCLES * NUM_BLOCKS + 64 * NUM_TABLE_LOADS + 500;

    logic                               clk;
    logic                               resetn;
    logic                               cfg_we_i;
    logic [5:0]                         cfg_addr_i;
    logic [jpeg_pkg::RECIP_W-1:0]       cfg_data_i;
    logic [7:0][CW-1:0]                 coef_i;
    logic [2:0]                         coef_row_i;
    logic                               coef_valid_i;
    logic                               coef_hold_o;
    logic [1:0][CW-1:0]                 zz_q_o;
    logic [jpeg_pkg::PAIR_IDX_W-1:0]    zz_idx_o;
    logic                               zz_valid_o;
    logic                               zz_hold_i;

    integer                             seed;
    int                                 errors;
    int                                 cycles;
    int                                 hold_mode;
    logic [jpeg_pkg::RECIP_W-1:0]       tbl_model [64];
    logic signed [CW-1:0]               blk [64];
    logic [5:0]                         scan_pos [64];
    logic signed [CW-1:0]               exp_coef [$];
    logic [jpeg_pkg::PAIR_IDX_W-1:0]    exp_pair;
    logic                               held_prev;
    logic [1:0][CW-1:0]                 prev_q;
    logic [jpeg_pkg::PAIR_IDX_W-1:0]    prev_idx;

    jpeg_quant_zigzag #(
        .CW             (CW)
    ) u_dut (
        .clk            (clk),
        .resetn         (resetn),
        .cfg_we_i       (cfg_we_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_data_i     (cfg_data_i),
        .coef_i         (coef_i),
        .coef_row_i     (coef_row_i),
        .coef_valid_i   (coef_valid_i),
        .coef_hold_o    (coef_hold_o),
        .zz_q_o         (zz_q_o),
        .zz_idx_o       (zz_idx_o),
        .zz_valid_o     (zz_valid_o),
        .zz_hold_i      (zz_hold_i)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Compare tasks and reference model
    // --------------------------------------------------

    task automatic check_coef(input string name, input logic signed [CW-1:0] exp_v,
                              input logic signed [CW-1:0] act);
        if (act !== exp_v) begin
            errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp_v, act);
        end
    endtask

    task automatic check_idx(input string name, input logic [4:0] exp_v, input logic [4:0] act);
        if (act !== exp_v) begin
            errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp_v, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act);
        if (act !== exp_v) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp_v, act);
        end
    endtask

    // Walk the anti-diagonals, alternating direction, to get the scan order
    task automatic build_scan_order();
        int idx;
        int r_lo;
        int r_hi;
        idx = 0;
        for (int s = 0; s < 15; s++) begin
            r_lo = (s > 7) ? s - 7 : 0;
            r_hi = (s < 7) ? s : 7;
            if (s % 2 == 0) begin
                for (int r = r_hi; r >= r_lo; r--) begin
                    scan_pos[r * 8 + s - r] = 6'(idx);
                    idx++;
                end
            end else begin
                for (int r = r_lo; r <= r_hi; r++) begin
                    scan_pos[r * 8 + s - r] = 6'(idx);
                    idx++;
                end
            end
        end
    endtask

    // Round half up: add half of 2^16, then floor
    function automatic logic signed [CW-1:0] quantize(input logic signed [CW-1:0] c,
                                                      input logic [15:0] r);
        longint p;
        p = longint'(c) * longint'(r) + 32768;
        return CW'(p >>> 16);
    endfunction

    task automatic push_expected();
        logic signed [CW-1:0] scan [64];
        for (int pos = 0; pos < 64; pos++) begin
            scan[scan_pos[pos]] = quantize(blk[pos], tbl_model[pos]);
        end
        for (int k = 0; k < 64; k++) begin
            exp_coef.push_back(scan[k]);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    task automatic load_table(input bit use_random, input logic [15:0] value);
        for (int a = 0; a < 64; a++) begin
            @(negedge clk);
            cfg_we_i   = 1'b1;
            cfg_addr_i = 6'(a);
            cfg_data_i = use_random ? 16'($random(seed)) : value;
            tbl_model[a] = cfg_data_i;
        end
        @(negedge clk);
        cfg_we_i = 1'b0;
    endtask

    task automatic fill_random();
        for (int pos = 0; pos < 64; pos++) begin
            blk[pos] = CW'($random(seed));
        end
    endtask

    task automatic send_row(input int r);
        @(negedge clk);
        for (int c = 0; c < 8; c++) begin
            coef_i[c] = blk[r * 8 + c];
        end
        coef_row_i   = 3'(r);
        coef_valid_i = 1'b1;
        while (coef_hold_o) begin
            @(negedge clk);
        end
    endtask

    task automatic send_block();
        push_expected();
        for (int r = 0; r < 8; r++) begin
            send_row(r);
        end
    endtask

    task automatic stop_rows();
        @(negedge clk);
        coef_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_coef.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Sets the output hold, then takes each pair that the next rising edge consumes
    always @(negedge clk) begin
        if (resetn) begin
            case (hold_mode)
                0:       zz_hold_i = 1'b0;
                1:       zz_hold_i = 1'($random(seed));
                default: zz_hold_i = 1'b1;
            endcase
            if (held_prev) begin
                check_flag("zz_valid_o", 1'b1, zz_valid_o);
                check_idx("zz_idx_o", prev_idx, zz_idx_o);
                check_coef("zz_q_o[0]", prev_q[0], zz_q_o[0]);
                check_coef("zz_q_o[1]", prev_q[1], zz_q_o[1]);
            end
            if (zz_valid_o && !zz_hold_i) begin
                if (exp_coef.size() < 2) begin
                    errors++;
                    $display("Pair %0d came out while no block was expected", zz_idx_o);
                end else begin
                    check_idx("zz_idx_o", exp_pair, zz_idx_o);
                    check_coef("zz_q_o[0]", exp_coef.pop_front(), zz_q_o[0]);
                    check_coef("zz_q_o[1]", exp_coef.pop_front(), zz_q_o[1]);
                    exp_pair++;
                end
            end
            held_prev = zz_valid_o && zz_hold_i;
            prev_q    = zz_q_o;
            prev_idx  = zz_idx_o;
        end
    end

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------

    task automatic test_reset();
        check_flag("zz_valid_o", 1'b0, zz_valid_o);
        check_flag("coef_hold_o", 1'b0, coef_hold_o);
        fill_random();
        send_block();
        stop_rows();
        wait_drain();
    endtask

    task automatic test_table_load();
        load_table(1'b1, 16'h0000);
        fill_random();
        send_block();
        stop_rows();
        wait_drain();
    endtask

    // With reciprocal 0xFFFF the quotient equals the coefficient
    task automatic test_scan_order();
        load_table(1'b0, 16'hFFFF);
        for (int pos = 0; pos < 64; pos++) begin
            blk[pos] = CW'(pos);
        end
        send_block();
        stop_rows();
        wait_drain();
    endtask

    task automatic test_back_pressure();
        hold_mode = 1;
        for (int b = 0; b < 3; b++) begin
            fill_random();
            send_block();
        end
        stop_rows();
        wait_drain();
        hold_mode = 0;
    endtask

    task automatic test_ping_pong();
        hold_mode = 2;
        fill_random();
        send_block();
        fill_random();
        send_block();
        fill_random();
        push_expected();
        send_row(0);
        for (int i = 0; i < 30; i++) begin
            @(negedge clk);
            check_flag("coef_hold_o", 1'b1, coef_hold_o);
        end
        hold_mode = 0;
        for (int r = 1; r < 8; r++) begin
            send_row(r);
        end
        stop_rows();
        wait_drain();
    endtask

    initial begin
        seed         = 32'he44869b3;
        errors       = 0;
        cycles       = 0;
        hold_mode    = 0;
        held_prev    = 1'b0;
        exp_pair     = '0;
        prev_q       = '0;
        prev_idx     = '0;
        clk          = 1'b0;
        resetn       = 1'b0;
        cfg_we_i     = 1'b0;
        cfg_addr_i   = '0;
        cfg_data_i   = '0;
        coef_i       = '0;
        coef_row_i   = '0;
        coef_valid_i = 1'b0;
        zz_hold_i    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            tbl_model[i] = 16'h8000;
        end
        build_scan_order();

        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        test_reset();
        test_table_load();
        test_scan_order();
        test_back_pressure();
        test_ping_pong();

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: design/jpeg_quant_zigzag.sv
`timescale 1ns/100ps

module jpeg_quant_zigzag #(
    parameter int CW = 12
) (
    input  logic                                clk,
    input  logic                                resetn,

    input  logic                                cfg_we_i,
    input  logic [5:0]                          cfg_addr_i,
    input  logic [jpeg_pkg::RECIP_W-1:0]        cfg_data_i,

    input  logic [7:0][CW-1:0]                  coef_i,
    input  logic [2:0]                          coef_row_i,
    input  logic                                coef_valid_i,
    output logic                                coef_hold_o,

    output logic [1:0][CW-1:0]                  zz_q_o,
    output logic [jpeg_pkg::PAIR_IDX_W-1:0]     zz_idx_o,
    output logic                                zz_valid_o,
    input  logic                                zz_hold_i
);

    logic [2:0]                         tbl_row;
    logic [7:0][jpeg_pkg::RECIP_W-1:0]  recip_row;

    logic [7:0][CW-1:0]                 qrow;
    logic [2:0]                         qrow_idx;
    logic                               qrow_valid;
    logic                               qrow_hold;

    quant_table_regs u_table (
        .clk            (clk),
        .resetn         (resetn),
        .cfg_we_i       (cfg_we_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_data_i     (cfg_data_i),
        .rd_row_i       (tbl_row),
        .recip_row_o    (recip_row)
    );

    coef_quantizer #(
        .CW             (CW)
    ) u_quant (
        .clk            (clk),
        .resetn         (resetn),
        .coef_i         (coef_i),
        .coef_row_i     (coef_row_i),
        .coef_valid_i   (coef_valid_i),
        .coef_hold_o    (coef_hold_o),
        .tbl_row_o      (tbl_row),
        .recip_row_i    (recip_row),
        .q_o            (qrow),
        .q_row_o        (qrow_idx),
        .q_valid_o      (qrow_valid),
        .q_hold_i       (qrow_hold)
    );

    zigzag_buffer #(
        .CW             (CW)
    ) u_zigzag (
        .clk            (clk),
        .resetn         (resetn),
        .d_i            (qrow),
        .d_row_i        (qrow_idx),
        .d_valid_i      (qrow_valid),
        .d_hold_o       (qrow_hold),
        .q_o            (zz_q_o),
        .q_idx_o        (zz_idx_o),
        .q_valid_o      (zz_valid_o),
        .q_hold_i       (zz_hold_i)
    );

endmodule

// File: design/zigzag_buffer.sv
`timescale 1ns/100ps

module zigzag_buffer #(
    parameter int CW = 12
) (
    input  logic                                clk,
    input  logic                                resetn,

    input  logic [7:0][CW-1:0]                  d_i,
    input  logic [2:0]                          d_row_i,
    input  logic                                d_valid_i,
    output logic                                d_hold_o,

    output logic [1:0][CW-1:0]                  q_o,
    output logic [jpeg_pkg::PAIR_IDX_W-1:0]     q_idx_o,
    output logic                                q_valid_o,
    input  logic                                q_hold_i
);

    // Each bank holds one coefficient of every pair for both blocks
    localparam int BANK_AW    = jpeg_pkg::PAIR_IDX_W + 1;
    localparam int BANK_DEPTH = jpeg_pkg::BLOCK_COEFS;

    logic [1:0]                         wptr;
    logic [1:0]                         rptr;
    logic                               full;
    logic                               empty;

    logic [2:0]                         wr_col;
    logic                               wr_en;
    logic [5:0]                         wr_zz;
    logic [BANK_AW-1:0]                 wr_addr;
    logic [CW-1:0]                      wr_data;

    logic [jpeg_pkg::PAIR_IDX_W-1:0]    rd_idx;
    logic [BANK_AW-1:0]                 rd_addr;
    logic                               rd_en;

    logic [CW-1:0]                      bank_even [BANK_DEPTH];
    logic [CW-1:0]                      bank_odd  [BANK_DEPTH];

    // --------------------------------------------------
    // Block pointers
    // --------------------------------------------------

    // Pointers carry one wrap bit above the block select
    assign full  = (wptr[1] != rptr[1]) && (wptr[0] == rptr[0]);
    assign empty = (wptr == rptr);

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------

    // The row is released only on its last column
    assign d_hold_o = full | (wr_col != 3'd7);
    assign wr_en    = d_valid_i & ~full;

    assign wr_zz    = jpeg_pkg::zigzag_index({d_row_i, wr_col});
    assign wr_addr  = {wptr[0], wr_zz[5:1]};
    assign wr_data  = d_i[wr_col];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_col <= 3'd0;
            wptr   <= 2'd0;
        end else if (wr_en) begin
            wr_col <= wr_col + 3'd1;
            if (wr_col == 3'd7 && d_row_i == 3'd7) begin
                wptr <= wptr + 2'd1;
            end
        end
    end

    // Even zigzag positions land in one bank, odd ones in the other
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_zz[0]) begin
                bank_odd[wr_addr] <= wr_data;
            end else begin
                bank_even[wr_addr] <= wr_data;
            end
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------

    assign rd_en   = ~q_hold_i & ~empty;
    assign rd_addr = {rptr[0], rd_idx};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr      <= 2'd0;
            rd_idx    <= '0;
            q_valid_o <= 1'b0;
        end else if (!q_hold_i) begin
            q_valid_o <= ~empty;
            if (!empty) begin
                rd_idx <= rd_idx + 1'b1;
                // Last pair frees the block for the writer
                if (&rd_idx) begin
                    rptr <= rptr + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            q_o[0]  <= bank_even[rd_addr];
            q_o[1]  <= bank_odd[rd_addr];
            q_idx_o <= rd_idx;
        end
    end

    // At most two blocks wait, and a write only goes in while fewer than two do
    no_write_while_full: assert property (
        @(posedge clk) disable iff (!resetn)
        wr_en |-> (2'(wptr - rptr) < 2'd2)
    ) else $error("bank write while both blocks are full");

endmodule

// File: design/coef_quantizer.sv
`timescale 1ns/100ps

module coef_quantizer #(
    parameter int CW = 12
) (
    input  logic                                clk,
    input  logic                                resetn,

    input  logic [7:0][CW-1:0]                  coef_i,
    input  logic [2:0]                          coef_row_i,
    input  logic                                coef_valid_i,
    output logic                                coef_hold_o,

    output logic [2:0]                          tbl_row_o,
    input  logic [7:0][jpeg_pkg::RECIP_W-1:0]   recip_row_i,

    output logic [7:0][CW-1:0]                  q_o,
    output logic [2:0]                          q_row_o,
    output logic                                q_valid_o,
    input  logic                                q_hold_i
);

    // Coefficient times reciprocal, reciprocal taken as a positive signed value
    localparam int PW = CW + jpeg_pkg::RECIP_W + 1;

    localparam logic signed [PW-1:0] ROUND_HALF = PW'(1) << (jpeg_pkg::RECIP_SHIFT - 1);

    logic signed [PW-1:0]   prod   [8];
    logic signed [PW-1:0]   scaled [8];
    logic [7:0][CW-1:0]     q_next;
    logic                   accept;
    logic [2:0]             exp_row;

    // --------------------------------------------------
    // Scaling
    // --------------------------------------------------

    assign tbl_row_o = coef_row_i;

    // Round half up, then drop the fraction bits
    always_comb begin
        for (int c = 0; c < jpeg_pkg::BLOCK_ROWS; c++) begin
            prod[c]   = $signed(coef_i[c]) * $signed({1'b0, recip_row_i[c]});
            scaled[c] = (prod[c] + ROUND_HALF) >>> jpeg_pkg::RECIP_SHIFT;
            q_next[c] = scaled[c][CW-1:0];
        end
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------

    // The register only blocks the input when its row cannot leave
    assign coef_hold_o = q_valid_o & q_hold_i;
    assign accept      = coef_valid_i & ~coef_hold_o;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            q_valid_o <= 1'b0;
        end else if (!coef_hold_o) begin
            q_valid_o <= coef_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q_o     <= q_next;
            q_row_o <= coef_row_i;
        end
    end

    // Row expected next, a block always starts at row 0
    always_ff @(posedge clk) begin
        if (!resetn) begin
            exp_row <= 3'd0;
        end else if (accept) begin
            exp_row <= coef_row_i + 3'd1;
        end
    end

    row_in_order: assert property (
        @(posedge clk) disable iff (!resetn)
        accept |-> coef_row_i == exp_row
    ) else $error("coefficient row %0d accepted, expected %0d", coef_row_i, exp_row);

endmodule

// File: design/quant_table_regs.sv
`timescale 1ns/100ps

module quant_table_regs (
    input  logic                                clk,
    input  logic                                resetn,

    input  logic                                cfg_we_i,
    input  logic [5:0]                          cfg_addr_i,
    input  logic [jpeg_pkg::RECIP_W-1:0]        cfg_data_i,

    input  logic [2:0]                          rd_row_i,
    output logic [7:0][jpeg_pkg::RECIP_W-1:0]   recip_row_o
);

    // Default entry divides by two
    localparam logic [jpeg_pkg::RECIP_W-1:0] RECIP_RESET = 16'h8000;

    logic [jpeg_pkg::RECIP_W-1:0] recip_q [jpeg_pkg::BLOCK_COEFS];

    // --------------------------------------------------
    // Table write
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < jpeg_pkg::BLOCK_COEFS; i++) begin
                recip_q[i] <= RECIP_RESET;
            end
        end else if (cfg_we_i) begin
            recip_q[cfg_addr_i] <= cfg_data_i;
        end
    end

    // --------------------------------------------------
    // Row read
    // --------------------------------------------------

    // All eight entries of one row come out together for the multipliers
    always_comb begin
        for (int c = 0; c < jpeg_pkg::BLOCK_ROWS; c++) begin
            recip_row_o[c] = recip_q[{rd_row_i, 3'(c)}];
        end
    end

    cfg_addr_known: assert property (
        @(posedge clk) disable iff (!resetn)
        cfg_we_i |-> !$isunknown(cfg_addr_i)
    ) else $error("quant table written with unknown address");

endmodule

// File: design/jpeg_pkg.sv
package jpeg_pkg;

    // --------------------------------------------------
    // Widths and block geometry
    // --------------------------------------------------

    // A reciprocal is an unsigned fraction of 2^16
    localparam int RECIP_W     = 16;
    localparam int RECIP_SHIFT = 16;

    localparam int BLOCK_ROWS  = 8;
    localparam int BLOCK_COEFS = 64;

    // Two coefficients per pair, 32 pairs per block
    localparam int PAIR_IDX_W  = 5;

    // --------------------------------------------------
    // Zigzag scan order
    // --------------------------------------------------

    // Scan position of each natural position, row 0 first, column 0 leftmost
    localparam logic [0:63][5:0] ZZ_MAP = {
        6'd0,  6'd1,  6'd5,  6'd6,  6'd14, 6'd15, 6'd27, 6'd28,
        6'd2,  6'd4,  6'd7,  6'd13, 6'd16, 6'd26, 6'd29, 6'd42,
        6'd3,  6'd8,  6'd12, 6'd17, 6'd25, 6'd30, 6'd41, 6'd43,
        6'd9,  6'd11, 6'd18, 6'd24, 6'd31, 6'd40, 6'd44, 6'd53,
        6'd10, 6'd19, 6'd23, 6'd32, 6'd39, 6'd45, 6'd52, 6'd54,
        6'd20, 6'd22, 6'd33, 6'd38, 6'd46, 6'd51, 6'd55, 6'd60,
        6'd21, 6'd34, 6'd37, 6'd47, 6'd50, 6'd56, 6'd59, 6'd61,
        6'd35, 6'd36, 6'd48, 6'd49, 6'd57, 6'd58, 6'd62, 6'd63
    };

    // Position is row * 8 + column
    function automatic logic [5:0] zigzag_index(input logic [5:0] pos);
        return ZZ_MAP[pos];
    endfunction

endpackage
